// ==== core_patterns.txt ====
// First value: record count. Then one record per line, all hex:
// insn pc rs1 rs2 flush exp_valid exp_rf_we exp_rd exp_result
17
002081B3 0 1234 FFFFFFFFFFFFFFFF 0 1 1 03 1233
002081B3 0 1 1 1 0 0 03 0
0020E333 0 00FF FF00 0 1 1 06 FFFF
40208233 0 5 7 0 1 1 04 FFFFFFFFFFFFFFFE
0020F2B3 0 F0F0F0F0F0F0F0F0 0FF00FF00FF00FF0 0 1 1 05 00F000F000F000F0
0020C3B3 0 AAAAAAAAAAAAAAAA FFFFFFFFFFFFFFFF 0 1 1 07 5555555555555555
00209433 0 1 43 0 1 1 08 8
0020D4B3 0 8000000000000000 3F 0 1 1 09 1
4020D533 0 8000000000000000 4 0 1 1 0A F800000000000000
0020A5B3 0 FFFFFFFFFFFFFFFF 1 0 1 1 0B 1
0020B633 0 FFFFFFFFFFFFFFFF 1 0 1 1 0C 0
FFB08693 0 10 0 0 1 1 0D B
4210D713 0 8000000000000000 0 0 1 1 0E FFFFFFFFC0000000
02809793 0 3 0 0 1 1 0F 30000000000
80000837 0 0 0 0 1 1 10 FFFFFFFF80000000
12345897 1000 0 0 0 1 1 11 12346000
004000EF 2000 0 0 0 1 1 01 2004
010302E7 3000 55 0 0 1 1 05 3004
FFC42383 0 1000 0 0 1 1 07 FFC
00144483 0 2000 0 0 1 1 09 2001
00243C23 0 100 1234 0 1 0 18 118
FE241F23 0 1000 0 0 1 0 1E FFE
0000007F 0 0 0 0 0 0 00 0

// ==== tb.f ====
isa_pkg.sv
pipe_pkg.sv
rv_decode.sv
stage_reg.sv
rv_exec.sv
rv_core_slice.sv
core_slice_chk.sv
tb_core_slice.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_slice
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_core_slice.sv ====
`timescale 1ns/1ps

module tb_core_slice;

   localparam int MAX_PATS = 64;
   localparam int REC_W    = 9;

   typedef struct packed {
      logic        rf_we;
      logic [4:0]  rd;
      logic [63:0] result;
      logic        load;
      logic        store;
      logic [3:0]  size;
      logic        sigext;
      logic [31:0] due;
   } expect_t;

   logic        clk;
   logic        rst;
   logic        flush;
   logic        in_valid;
   logic [31:0] in_insn;
   logic [63:0] in_pc;
   logic [63:0] in_rs1_val;
   logic [63:0] in_rs2_val;
   logic        out_valid;
   logic        out_rf_we;
   logic [4:0]  out_rd;
   logic [63:0] out_result;
   logic        out_load;
   logic        out_store;
   logic [3:0]  out_size;
   logic        out_sigext;

   // Word 0 is the record count, records follow
   logic [63:0] pat_mem [0:MAX_PATS*REC_W];
   expect_t     exp_q[$];
   int          num_pats;
   int unsigned cycle;
   int unsigned cycle_limit;
   int          value_errs;
   int          other_errs;
   integer      seed;

   rv_core_slice i_dut (.*);

   bind rv_core_slice core_slice_chk u_chk (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .out_valid (out_valid),
      .out_rf_we (out_rf_we),
      .out_load  (out_load),
      .out_store (out_store)
   );

   always #50 clk = ~clk;

   function automatic expect_t expect_of(input int base);
      expect_t    e;
      logic [6:0] opc;
      logic [2:0] f3;
      opc      = pat_mem[base][6:0];
      f3       = pat_mem[base][14:12];
      e.rf_we  = pat_mem[base+6][0];
      e.rd     = pat_mem[base+7][4:0];
      e.result = pat_mem[base+8];
      // Memory flags follow opcode and funct3
      e.load   = (opc == 7'b0000011);
      e.store  = (opc == 7'b0100011);
      e.size   = 4'b0001 << f3[1:0];
      e.sigext = e.load && !f3[2];
      e.due    = cycle + 2;
      return e;
   endfunction

   task automatic report_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] want);
      value_errs++;
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
   endtask

   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, outputs never drained", cycle);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   always @(posedge clk)
   begin
      expect_t e;
      if (!rst && out_valid)
      begin
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("Output valid at %0d ns with no instruction outstanding", $time);
         end
         else
         begin
            e = exp_q.pop_front();
            assert (cycle == e.due) else report_mismatch("cycle", 64'(cycle), 64'(e.due));
            assert (out_rf_we === e.rf_we)
               else report_mismatch("rf_we", 64'(out_rf_we), 64'(e.rf_we));
            assert (out_rd === e.rd) else report_mismatch("rd", 64'(out_rd), 64'(e.rd));
            assert (out_result === e.result)
               else report_mismatch("result", out_result, e.result);
            assert (out_load === e.load)
               else report_mismatch("load", 64'(out_load), 64'(e.load));
            assert (out_store === e.store)
               else report_mismatch("store", 64'(out_store), 64'(e.store));
            if (e.load || e.store)
            begin
               assert (out_size === e.size)
                  else report_mismatch("size", 64'(out_size), 64'(e.size));
               assert (out_sigext === e.sigext)
                  else report_mismatch("sigext", 64'(out_sigext), 64'(e.sigext));
            end
         end
      end
   end

   initial
   begin
      int gap;
      int base;
      clk        = 1'b0;
      rst        = 1'b1;
      flush      = 1'b0;
      in_valid   = 1'b0;
      in_insn    = '0;
      in_pc      = '0;
      in_rs1_val = '0;
      in_rs2_val = '0;
      cycle      = 0;
      value_errs = 0;
      other_errs = 0;
      seed       = 32'hdaef_4454;
      $readmemh("core_patterns.txt", pat_mem);
      num_pats    = int'(pat_mem[0]);
      cycle_limit = num_pats * 3 + 20;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      // One empty slot so the idle outputs after reset are seen
      @(negedge clk);
      for (int i = 0; i < num_pats; i++)
      begin
         base       = 1 + i * REC_W;
         in_valid   = 1'b1;
         in_insn    = pat_mem[base][31:0];
         in_pc      = pat_mem[base+1];
         in_rs1_val = pat_mem[base+2];
         in_rs2_val = pat_mem[base+3];
         flush      = pat_mem[base+4][0];
         if (pat_mem[base+5][0])
            exp_q.push_back(expect_of(base));
         @(negedge clk);
         in_valid = 1'b0;
         flush    = 1'b0;
         // First records run back to back
         gap = (i < 4) ? 0 : $unsigned($random(seed)) % 3;
         repeat (gap) @(negedge clk);
      end
      repeat (4) @(negedge clk);
      if (exp_q.size() != 0)
      begin
         other_errs += exp_q.size();
         $display("%0d expected results never appeared on the outputs", exp_q.size());
      end
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== core_slice_chk.sv ====
`timescale 1ns/1ps

module core_slice_chk (
   input logic clk,
   input logic rst,
   input logic in_valid,
   input logic out_valid,
   input logic out_rf_we,
   input logic out_load,
   input logic out_store
);

   // Pipeline is empty right after reset
   assert property (@(posedge clk) rst |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

   // Two register stages between input and output
   assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 2))
      else $error("out_valid without an input instruction two cycles earlier");

   assert property (@(posedge clk) disable iff (rst) out_rf_we |-> out_valid)
      else $error("out_rf_we high while out_valid is low");

   assert property (@(posedge clk) disable iff (rst) out_load |-> out_valid)
      else $error("out_load high while out_valid is low");

   assert property (@(posedge clk) disable iff (rst) !(out_load && out_store))
      else $error("out_load and out_store high together");

endmodule

// ==== rv_core_slice.sv ====
`timescale 1ns/1ps

module rv_core_slice (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       flush,
   input  logic                       in_valid,
   input  logic [isa_pkg::INSN_W-1:0] in_insn,
   input  logic [isa_pkg::XLEN-1:0]   in_pc,
   input  logic [isa_pkg::XLEN-1:0]   in_rs1_val,
   input  logic [isa_pkg::XLEN-1:0]   in_rs2_val,
   output logic                       out_valid,
   output logic                       out_rf_we,
   output logic [isa_pkg::REG_AW-1:0] out_rd,
   output logic [isa_pkg::XLEN-1:0]   out_result,
   output logic                       out_load,
   output logic                       out_store,
   output logic [isa_pkg::SIZE_W-1:0] out_size,
   output logic                       out_sigext
);

   pipe_pkg::dec_ctrl_t dec_ctrl;
   pipe_pkg::dec_data_t dec_data;
   pipe_pkg::dec_ctrl_t exu_ctrl;
   pipe_pkg::dec_data_t exu_data;
   pipe_pkg::wb_ctrl_t  exu_wb_ctrl;
   pipe_pkg::wb_data_t  exu_wb_data;
   pipe_pkg::wb_ctrl_t  wb_ctrl;
   pipe_pkg::wb_data_t  wb_data;

   rv_decode u_decode (
      .insn    (in_insn),
      .pc      (in_pc),
      .rs1_val (in_rs1_val),
      .rs2_val (in_rs2_val),
      .valid   (in_valid),
      .ctrl    (dec_ctrl),
      .data    (dec_data)
   );

   stage_reg #(
      .ctrl_t (pipe_pkg::dec_ctrl_t),
      .data_t (pipe_pkg::dec_data_t)
   ) u_idu_exu (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .ctrl_in  (dec_ctrl),
      .data_in  (dec_data),
      .ctrl_out (exu_ctrl),
      .data_out (exu_data)
   );

   rv_exec u_exec (
      .ctrl    (exu_ctrl),
      .data    (exu_data),
      .wb_ctrl (exu_wb_ctrl),
      .wb_data (exu_wb_data)
   );

   // Nothing is killed past execute
   stage_reg #(
      .ctrl_t (pipe_pkg::wb_ctrl_t),
      .data_t (pipe_pkg::wb_data_t)
   ) u_exu_wb (
      .clk      (clk),
      .rst      (rst),
      .flush    (1'b0),
      .ctrl_in  (exu_wb_ctrl),
      .data_in  (exu_wb_data),
      .ctrl_out (wb_ctrl),
      .data_out (wb_data)
   );

   assign out_valid  = wb_ctrl.valid;
   assign out_rf_we  = wb_ctrl.rf_we;
   assign out_load   = wb_ctrl.lsu_load;
   assign out_store  = wb_ctrl.lsu_store;
   assign out_rd     = wb_data.rd;
   assign out_result = wb_data.result;
   assign out_size   = wb_data.lsu_size;
   assign out_sigext = wb_data.lsu_sigext;

endmodule

// ==== rv_exec.sv ====
`timescale 1ns/1ps

module rv_exec (
   input  pipe_pkg::dec_ctrl_t ctrl,
   input  pipe_pkg::dec_data_t data,
   output pipe_pkg::wb_ctrl_t  wb_ctrl,
   output pipe_pkg::wb_data_t  wb_data
);

   localparam int XLEN = isa_pkg::XLEN;

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] sum;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_u;
   logic [5:0]      sh;

   // Store offset is split across the instruction word
   assign imm_i = {{(XLEN-12){data.imm12[11]}}, data.imm12};
   assign imm_s = {{(XLEN-12){data.insn[31]}}, data.insn[31:25], data.insn[11:7]};
   assign imm_u = {{(XLEN-32){data.imm20[19]}}, data.imm20, 12'b0};

   always_comb
   begin
      op_a = data.rs1_val;
      op_b = data.rs2_val;
      case (ctrl.op_sel)
         isa_pkg::SEL_RI12:   op_b = imm_i;
         isa_pkg::SEL_RIS:    op_b = imm_s;
         isa_pkg::SEL_RSHAMT: op_b = {{(XLEN-isa_pkg::SHAMT_W){1'b0}}, data.shamt};
         isa_pkg::SEL_PC_U:
         begin
            op_a = data.pc;
            op_b = imm_u;
         end
         isa_pkg::SEL_ZERO_U:
         begin
            op_a = '0;
            op_b = imm_u;
         end
         isa_pkg::SEL_PC4:
         begin
            op_a = data.pc;
            op_b = XLEN'(4);
         end
         default: ;
      endcase
   end

   assign sum = op_a + op_b;
   assign sh  = op_b[5:0];

   always_comb
   begin
      case (ctrl.fu_sel)
         isa_pkg::ALU_ADD:    alu_res = sum;
         isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
         isa_pkg::ALU_AND:    alu_res = op_a & op_b;
         isa_pkg::ALU_OR:     alu_res = op_a | op_b;
         isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
         isa_pkg::ALU_SLL:    alu_res = op_a << sh;
         isa_pkg::ALU_SRL:    alu_res = op_a >> sh;
         isa_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> sh);
         isa_pkg::ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         isa_pkg::ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
         isa_pkg::ALU_PASS_B: alu_res = op_b;
         default:             alu_res = '0;
      endcase
   end

   always_comb
   begin
      wb_ctrl.valid      = ctrl.valid;
      wb_ctrl.rf_we      = ctrl.rf_we;
      wb_ctrl.lsu_load   = ctrl.lsu_load;
      wb_ctrl.lsu_store  = ctrl.lsu_store;
      wb_data.rd         = data.rd;
      // Loads and stores report the effective address
      wb_data.result     = ctrl.wb_sel ? sum : alu_res;
      wb_data.lsu_size   = data.lsu_size;
      wb_data.lsu_sigext = data.lsu_sigext;
   end

endmodule

// ==== stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
   parameter type ctrl_t = logic,
   parameter type data_t = logic
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  flush,
   input  ctrl_t ctrl_in,
   input  data_t data_in,
   output ctrl_t ctrl_out,
   output data_t data_out
);

   // Killing the control fields is enough to drop the slot
   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         ctrl_out <= '0;
      end
      else
      begin
         ctrl_out <= ctrl_in;
      end
   end

   always_ff @(posedge clk)
   begin
      data_out <= data_in;
   end

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
   input  logic [isa_pkg::INSN_W-1:0] insn,
   input  logic [isa_pkg::XLEN-1:0]   pc,
   input  logic [isa_pkg::XLEN-1:0]   rs1_val,
   input  logic [isa_pkg::XLEN-1:0]   rs2_val,
   input  logic                       valid,
   output pipe_pkg::dec_ctrl_t        ctrl,
   output pipe_pkg::dec_data_t        data
);

   isa_pkg::opcode_e opcode;
   logic [2:0]       funct3;
   logic             known;

   assign opcode = isa_pkg::opcode_e'(insn[6:0]);
   assign funct3 = insn[14:12];

   // Shared funct3 map for OP and OP-IMM, alt is insn[30]
   function automatic isa_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
      isa_pkg::alu_op_e op;
      case (f3)
         3'b000:  op = alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
         3'b001:  op = isa_pkg::ALU_SLL;
         3'b010:  op = isa_pkg::ALU_SLT;
         3'b011:  op = isa_pkg::ALU_SLTU;
         3'b100:  op = isa_pkg::ALU_XOR;
         3'b101:  op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
         3'b110:  op = isa_pkg::ALU_OR;
         default: op = isa_pkg::ALU_AND;
      endcase
      return op;
   endfunction

   always_comb
   begin
      known = 1'b1;
      ctrl  = '0;
      case (opcode)
         isa_pkg::OPC_OP:
         begin
            ctrl.rf_we  = 1'b1;
            ctrl.op_sel = isa_pkg::SEL_RR;
            ctrl.fu_sel = alu_op_of(funct3, insn[30]);
         end
         isa_pkg::OPC_OP_IMM:
         begin
            ctrl.rf_we = 1'b1;
            if (funct3 == 3'b001 || funct3 == 3'b101)
            begin
               ctrl.op_sel = isa_pkg::SEL_RSHAMT;
               ctrl.fu_sel = alu_op_of(funct3, insn[30]);
            end
            else
            begin
               // No subtract form for immediates
               ctrl.op_sel = isa_pkg::SEL_RI12;
               ctrl.fu_sel = alu_op_of(funct3, 1'b0);
            end
         end
         isa_pkg::OPC_LUI:
         begin
            ctrl.rf_we  = 1'b1;
            ctrl.op_sel = isa_pkg::SEL_ZERO_U;
            ctrl.fu_sel = isa_pkg::ALU_PASS_B;
         end
         isa_pkg::OPC_AUIPC:
         begin
            ctrl.rf_we  = 1'b1;
            ctrl.op_sel = isa_pkg::SEL_PC_U;
            ctrl.fu_sel = isa_pkg::ALU_ADD;
         end
         isa_pkg::OPC_JAL, isa_pkg::OPC_JALR:
         begin
            // Link value only, no redirect here
            ctrl.rf_we  = 1'b1;
            ctrl.op_sel = isa_pkg::SEL_PC4;
            ctrl.fu_sel = isa_pkg::ALU_ADD;
         end
         isa_pkg::OPC_LOAD:
         begin
            ctrl.rf_we    = 1'b1;
            ctrl.op_sel   = isa_pkg::SEL_RI12;
            ctrl.fu_sel   = isa_pkg::ALU_ADD;
            ctrl.lsu_load = 1'b1;
            ctrl.wb_sel   = 1'b1;
         end
         isa_pkg::OPC_STORE:
         begin
            ctrl.op_sel    = isa_pkg::SEL_RIS;
            ctrl.fu_sel    = isa_pkg::ALU_ADD;
            ctrl.lsu_store = 1'b1;
            ctrl.wb_sel    = 1'b1;
         end
         default: known = 1'b0;
      endcase
      // Idle slots and unknown opcodes carry no control at all
      if (valid && known)
         ctrl.valid = 1'b1;
      else
         ctrl = '0;
   end

   always_comb
   begin
      data.rd         = insn[11:7];
      data.rs1_val    = rs1_val;
      data.rs2_val    = rs2_val;
      data.imm12      = insn[31:20];
      data.imm13      = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      data.imm20      = insn[31:12];
      data.imm21      = {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      data.shamt      = insn[25:20];
      data.lsu_sigext = (opcode == isa_pkg::OPC_LOAD) && !funct3[2];
      data.lsu_size   = '0;
      data.lsu_size[funct3[1:0]] = 1'b1;
      data.pc         = pc;
      data.insn       = insn;
   end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

   // Decode to execute, control part
   typedef struct packed {
      logic              valid;
      logic              rf_we;
      isa_pkg::op_sel_e  op_sel;
      isa_pkg::alu_op_e  fu_sel;
      logic              lsu_load;
      logic              lsu_store;
      // Result comes from the address path
      logic              wb_sel;
   } dec_ctrl_t;

   // Decode to execute, data part
   typedef struct packed {
      logic [isa_pkg::REG_AW-1:0]  rd;
      logic [isa_pkg::XLEN-1:0]    rs1_val;
      logic [isa_pkg::XLEN-1:0]    rs2_val;
      logic [11:0]                 imm12;
      logic [12:0]                 imm13;
      logic [19:0]                 imm20;
      logic [20:0]                 imm21;
      logic [isa_pkg::SHAMT_W-1:0] shamt;
      logic                        lsu_sigext;
      // One-hot access size, bit 0 is byte
      logic [isa_pkg::SIZE_W-1:0]  lsu_size;
      logic [isa_pkg::XLEN-1:0]    pc;
      logic [isa_pkg::INSN_W-1:0]  insn;
   } dec_data_t;

   // Execute to writeback
   typedef struct packed {
      logic valid;
      logic rf_we;
      logic lsu_load;
      logic lsu_store;
   } wb_ctrl_t;

   typedef struct packed {
      logic [isa_pkg::REG_AW-1:0] rd;
      logic [isa_pkg::XLEN-1:0]   result;
      logic [isa_pkg::SIZE_W-1:0] lsu_size;
      logic                       lsu_sigext;
   } wb_data_t;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

   // Data and field widths
   localparam int XLEN     = 64;
   localparam int INSN_W   = 32;
   localparam int REG_AW   = 5;
   localparam int SHAMT_W  = 6;
   localparam int SIZE_W   = 4;
   localparam int OP_SEL_W = 3;
   localparam int ALU_OPW  = 4;

   // Major opcodes handled by the slice
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   typedef enum logic [ALU_OPW-1:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_OR     = 4'd3,
      ALU_XOR    = 4'd4,
      ALU_SLL    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_SLT    = 4'd8,
      ALU_SLTU   = 4'd9,
      ALU_PASS_B = 4'd10
   } alu_op_e;

   // Operand A / operand B sources
   typedef enum logic [OP_SEL_W-1:0] {
      SEL_RR     = 3'd0,
      SEL_RI12   = 3'd1,
      SEL_RIS    = 3'd2,
      SEL_PC_U   = 3'd3,
      SEL_ZERO_U = 3'd4,
      SEL_PC4    = 3'd5,
      SEL_RSHAMT = 3'd6
   } op_sel_e;

endpackage
